// File: hw/uart_alu_pkg.sv
package uart_alu_pkg;

    // =========================================================
    // widths and opcodes
    // =========================================================
    parameter int DATA_W = 8;

    typedef logic [5:0] op_t;

    localparam op_t OP_ADD = 6'b100000;
    localparam op_t OP_SUB = 6'b100010;
    localparam op_t OP_AND = 6'b100100;
    localparam op_t OP_OR  = 6'b100101;
    localparam op_t OP_XOR = 6'b100110;
    localparam op_t OP_NOR = 6'b100111;
    localparam op_t OP_SRA = 6'b000011;
    localparam op_t OP_SRL = 6'b000010;

    // =========================================================
    // controller request and state
    // =========================================================
    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        op_t               op;
    } alu_req_t;

    typedef enum logic [2:0] {
        ST_GET_A  = 3'd0,
        ST_GET_B  = 3'd1,
        ST_GET_OP = 3'd2,
        ST_LATCH  = 3'd3,
        ST_SEND   = 3'd4
    } ctrl_state_t;

endpackage

// File: hw/baud_tick_gen.sv
module baud_tick_gen #(
    parameter int CLK_DIV = 27
) (
    input  logic clk,
    input  logic rst,
    output logic o_tick
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt    <= RELOAD;
            o_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt    <= RELOAD;              // one strobe per CLK_DIV cycles
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt - 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

// File: hw/uart_rx.sv
module uart_rx (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_tick,
    input  logic                            i_rx_line,
    output logic                            o_rx_done,
    output logic [uart_alu_pkg::DATA_W-1:0] o_rx_data
);

    import uart_alu_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         state;
    logic              rx_meta;
    logic              rx_s;
    logic              rx_prev;
    logic [3:0]        tick_cnt;
    logic [2:0]        bit_cnt;
    logic [DATA_W-1:0] shreg;

    // two flop sync plus one for edge detect
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx_line;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_s) begin    // falling edge only
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd7) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_s ? RX_IDLE : RX_DATA; // glitch check
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= RX_STOP;
                            end
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            o_rx_done <= rx_s;     // bad stop bit drops the byte
                            state     <= RX_IDLE;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data shift, lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && i_tick && tick_cnt == 4'd15) begin
            shreg <= {rx_s, shreg[DATA_W-1:1]};
        end
    end

    assign o_rx_data = shreg;

endmodule

// File: hw/uart_tx.sv
module uart_tx (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_tick,
    input  logic                            i_tx_start,
    input  logic [uart_alu_pkg::DATA_W-1:0] i_tx_data,
    output logic                            o_tx_line,
    output logic                            o_tx_done
);

    import uart_alu_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_ARM,
        TX_SEND
    } tx_state_t;

    tx_state_t       state;
    logic [3:0]      tick_cnt;
    logic [3:0]      bit_cnt;              // 0 start, 1..8 data, 9 stop
    logic [DATA_W:0] shreg;                // data plus stop bit

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_tx_line <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    o_tx_line <= 1'b1;
                    if (i_tx_start) begin
                        state <= TX_ARM;
                    end
                end
                TX_ARM: begin
                    if (i_tick) begin
                        o_tx_line <= 1'b0;         // start bit
                        tick_cnt  <= '0;
                        bit_cnt   <= '0;
                        state     <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            if (bit_cnt == 4'd9) begin
                                o_tx_done <= 1'b1;
                                state     <= TX_IDLE;
                            end else begin
                                o_tx_line <= shreg[0];
                                bit_cnt   <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && i_tx_start) begin
            shreg <= {1'b1, i_tx_data};
        end else if (state == TX_SEND && i_tick && tick_cnt == 4'd15) begin
            shreg <= {1'b1, shreg[DATA_W:1]};
        end
    end

endmodule

// File: hw/alu.sv
module alu (
    input  uart_alu_pkg::alu_req_t          i_req,
    output logic [uart_alu_pkg::DATA_W-1:0] o_result
);

    import uart_alu_pkg::*;

    logic [2:0] shamt;

    assign shamt = i_req.b[2:0];           // shifts use low three bits

    always_comb begin
        case (i_req.op)
            OP_ADD: o_result = i_req.a + i_req.b;  // wraps mod 256
            OP_SUB: o_result = i_req.a - i_req.b;
            OP_AND: o_result = i_req.a & i_req.b;
            OP_OR:  o_result = i_req.a | i_req.b;
            OP_XOR: o_result = i_req.a ^ i_req.b;
            OP_NOR: o_result = ~(i_req.a | i_req.b);
            OP_SRA: o_result = DATA_W'($signed(i_req.a) >>> shamt);
            OP_SRL: o_result = i_req.a >> shamt;
            default: o_result = '0;
        endcase
    end

endmodule

// File: hw/alu_uart_ctrl.sv
module alu_uart_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rx_done,
    input  logic [uart_alu_pkg::DATA_W-1:0] i_rx_data,
    input  logic [uart_alu_pkg::DATA_W-1:0] i_alu_result,
    output uart_alu_pkg::alu_req_t          o_req,
    output logic                            o_tx_start,
    output logic [uart_alu_pkg::DATA_W-1:0] o_tx_data,
    output logic [3:0]                      o_led
);

    import uart_alu_pkg::*;

    ctrl_state_t       state;
    ctrl_state_t       next_state;
    logic              next_tx_start;
    logic [DATA_W-1:0] next_tx_data;
    alu_req_t          next_req;

    // =========================================================
    // registers
    // =========================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= ST_GET_A;
            o_tx_start <= 1'b0;
            o_led      <= '0;
        end else begin
            o_led      <= {1'b0, state};   // one cycle behind
            state      <= next_state;
            o_tx_start <= next_tx_start;
        end
    end

    always_ff @(posedge clk) begin
        o_req     <= next_req;
        o_tx_data <= next_tx_data;
    end

    // =========================================================
    // next state
    // =========================================================
    always_comb begin
        next_state    = state;
        next_tx_start = 1'b0;
        next_tx_data  = o_tx_data;
        next_req      = o_req;
        case (state)
            ST_GET_A: begin
                if (i_rx_done) begin
                    next_req.a = i_rx_data;
                    next_state = ST_GET_B;
                end
            end
            ST_GET_B: begin
                if (i_rx_done) begin
                    next_req.b = i_rx_data;
                    next_state = ST_GET_OP;
                end
            end
            ST_GET_OP: begin
                if (i_rx_done) begin
                    next_req.op = i_rx_data[5:0];   // top two bits ignored
                    next_state  = ST_LATCH;
                end
            end
            ST_LATCH: begin
                next_tx_data  = i_alu_result;
                next_tx_start = 1'b1;               // high during ST_SEND
                next_state    = ST_SEND;
            end
            ST_SEND: next_state = ST_GET_A;
            default: next_state = ST_GET_A;
        endcase
    end

endmodule

// File: hw/uart_alu_top.sv
module uart_alu_top #(
    parameter int CLK_DIV = 27
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rx_line,
    output logic       o_tx_line,
    output logic [3:0] o_led
);

    import uart_alu_pkg::*;

    logic              tick;
    logic              rx_done;
    logic [DATA_W-1:0] rx_data;
    alu_req_t          req;
    logic [DATA_W-1:0] result;
    logic              tx_start;
    logic [DATA_W-1:0] tx_data;
    logic              tx_done;            // ctrl does not wait on it

    baud_tick_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_baud_tick_gen (
        .clk    (clk),
        .rst    (rst),
        .o_tick (tick)
    );

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .i_tick    (tick),
        .i_rx_line (i_rx_line),
        .o_rx_done (rx_done),
        .o_rx_data (rx_data)
    );

    alu_uart_ctrl u_alu_uart_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_rx_done    (rx_done),
        .i_rx_data    (rx_data),
        .i_alu_result (result),
        .o_req        (req),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data),
        .o_led        (o_led)
    );

    alu u_alu (
        .i_req    (req),
        .o_result (result)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx_line  (o_tx_line),
        .o_tx_done  (tx_done)
    );

endmodule

// File: tb/uart_alu_sva.sv
module uart_alu_sva (
    input logic                      clk,
    input logic                      rst,
    input logic                      rx_done,
    input logic                      tx_start,
    input logic                      tx_done,
    input logic                      o_tx_line,
    input logic [3:0]                o_led,
    input uart_alu_pkg::ctrl_state_t ctrl_state,
    input logic [1:0]                tx_state
);

    timeunit 1ns;
    timeprecision 1ps;

    import uart_alu_pkg::*;

    localparam logic [1:0] TX_IDLE_CODE = 2'd0;   // first literal of tx_state_t

    int   err_cnt = 0;
    logic op_seen;

    assign op_seen = rx_done && (ctrl_state == ST_GET_OP);

    // ============================================================
    // controller to transmitter strobe
    // ============================================================
    a_start_after_op: assert property (@(posedge clk) disable iff (!rst)
        tx_start |-> $past(op_seen, 2))
        else begin
            $error("tx_start without an opcode byte two cycles earlier");
            err_cnt = err_cnt + 1;
        end

    a_op_gives_start: assert property (@(posedge clk) disable iff (!rst)
        $past(op_seen, 2) |-> tx_start)
        else begin
            $error("opcode byte not followed by tx_start two cycles later");
            err_cnt = err_cnt + 1;
        end

    a_start_single: assert property (@(posedge clk) disable iff (!rst)
        tx_start |=> !tx_start)
        else begin
            $error("tx_start held longer than one cycle");
            err_cnt = err_cnt + 1;
        end

    // ============================================================
    // line and led
    // ============================================================
    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst)
        (tx_state == TX_IDLE_CODE) |-> o_tx_line)
        else begin
            $error("o_tx_line low while transmitter idle");
            err_cnt = err_cnt + 1;
        end

    a_done_at_frame_end: assert property (@(posedge clk) disable iff (!rst)
        tx_done |-> o_tx_line && (tx_state == TX_IDLE_CODE)
                    && ($past(tx_state) != TX_IDLE_CODE))
        else begin
            $error("tx_done outside the end of a frame");
            err_cnt = err_cnt + 1;
        end

    a_led_prev_state: assert property (@(posedge clk) disable iff (!rst)
        o_led == {1'b0, $past(ctrl_state)})
        else begin
            $error("o_led does not match previous controller state");
            err_cnt = err_cnt + 1;
        end

endmodule

bind uart_alu_top uart_alu_sva u_uart_alu_sva (
    .clk        (clk),
    .rst        (rst),
    .rx_done    (rx_done),
    .tx_start   (tx_start),
    .tx_done    (tx_done),
    .o_tx_line  (o_tx_line),
    .o_led      (o_led),
    .ctrl_state (u_alu_uart_ctrl.state),
    .tx_state   (u_uart_tx.state)
);

// File: tb/tb_uart_alu.sv
module tb_uart_alu;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_alu_pkg::*;

    localparam int CLK_DIV = 2;
    localparam int BIT_CYC = 16 * CLK_DIV;       // clk cycles per bit
    localparam int RX_WAIT = 2000;

    logic        clk;
    logic        rst;
    logic        i_rx_line;
    logic        o_tx_line;
    logic [3:0]  o_led;
    logic [31:0] lcg_state;

    uart_alu_top #(
        .CLK_DIV (CLK_DIV)
    ) u_uart_alu_top (
        .clk       (clk),
        .rst       (rst),
        .i_rx_line (i_rx_line),
        .o_tx_line (o_tx_line),
        .o_led     (o_led)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (u_uart_alu_top.u_uart_alu_sva.err_cnt != 0) begin
            $display("a concurrent assertion failed");
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // ============================================================
    // stimulus and reference
    // ============================================================
    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];                  // upper bits, better spread
    endfunction

    function automatic logic [7:0] ref_alu(input logic [7:0] a, input logic [7:0] b,
                                           input logic [5:0] op);
        logic [7:0] r;
        int         i;
        r = 8'h00;
        case (op)
            OP_ADD: r = a + b;
            OP_SUB: r = a - b;
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_NOR: r = ~(a | b);
            OP_SRA: begin
                r = a;
                for (i = 0; i < int'(b[2:0]); i++) begin
                    r = {r[7], r[7:1]};           // sign fill
                end
            end
            OP_SRL: begin
                r = a;
                for (i = 0; i < int'(b[2:0]); i++) begin
                    r = {1'b0, r[7:1]};
                end
            end
            default: r = 8'h00;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp,
                               input logic [7:0] got);
        assert (got === exp) else begin
            $display("** Error: %s expected %h actual %h", name, exp, got);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_idle(input string name, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_value({name, " line"}, 8'h01, {7'h00, o_tx_line});
            check_value({name, " led"}, 8'h00, {4'h0, o_led});
        end
    endtask

    // ============================================================
    // serial host model
    // ============================================================
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, data, 1'b0};
        @(posedge clk);
        for (i = 0; i < 10; i++) begin
            i_rx_line <= frame[i];
            repeat (BIT_CYC) @(posedge clk);
        end
        i_rx_line <= 1'b1;
    endtask

    task automatic recv_byte(input string name, output logic [7:0] data);
        int waited;
        int i;
        waited = 0;
        data   = 8'h00;
        @(negedge clk);
        while (o_tx_line && waited < RX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (o_tx_line) begin
            $display("%s: no start bit on o_tx_line within %0d cycles", name, RX_WAIT);
            $display("TB FAILED");
            $fatal(1, "reply timeout");
        end
        repeat (BIT_CYC / 2) @(negedge clk);     // middle of start bit
        check_value({name, " start bit"}, 8'h00, {7'h00, o_tx_line});
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge clk);
            data[i] = o_tx_line;
        end
        repeat (BIT_CYC) @(negedge clk);
        check_value({name, " stop bit"}, 8'h01, {7'h00, o_tx_line});
    endtask

    task automatic run_cmd(input string name, input logic [7:0] a, input logic [7:0] b,
                           input logic [7:0] op_byte);
        logic [7:0] exp;
        logic [7:0] got;
        exp = ref_alu(a, b, op_byte[5:0]);
        fork
            begin
                send_byte(a, 1'b1);
                send_byte(b, 1'b1);
                send_byte(op_byte, 1'b1);
            end
            recv_byte(name, got);
        join
        check_value(name, exp, got);
    endtask

    task automatic run_rand(input string name, input logic [7:0] op_byte);
        logic [7:0] a;
        logic [7:0] b;
        a = rand_byte();
        b = rand_byte();
        run_cmd(name, a, b, op_byte);
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int n;
        clk       = 1'b0;
        rst       = 1'b0;
        i_rx_line = 1'b1;
        lcg_state = 32'hdbe9;
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        check_idle("reset_idle", 40);

        run_cmd("add_wrap", 8'hff, 8'h01, {2'b00, OP_ADD});
        run_cmd("sub_wrap", 8'h00, 8'h01, {2'b00, OP_SUB});
        for (n = 0; n < 2; n++) begin
            run_rand("add_rand", {2'b00, OP_ADD});
            run_rand("sub_rand", {2'b00, OP_SUB});
            run_rand("and_rand", {2'b00, OP_AND});
            run_rand("or_rand", {2'b00, OP_OR});
            run_rand("xor_rand", {2'b00, OP_XOR});
            run_rand("nor_rand", {2'b00, OP_NOR});
        end

        // top opcode bits set, must be ignored
        run_cmd("sra_neg", 8'h90, 8'h0b, {2'b11, OP_SRA});
        run_rand("sra_rand", {2'b11, OP_SRA});
        run_rand("srl_rand", {2'b11, OP_SRL});
        run_cmd("srl_full", 8'hff, 8'hf7, {2'b11, OP_SRL});

        run_rand("undef_op", 8'h3f);

        send_byte(8'ha5, 1'b0);                   // low stop bit
        check_idle("bad_frame", 2 * BIT_CYC);
        run_rand("after_bad_frame", {2'b00, OP_ADD});

        if (u_uart_alu_top.u_uart_alu_sva.err_cnt != 0) begin
            $display("concurrent assertions failed %0d times",
                     u_uart_alu_top.u_uart_alu_sva.err_cnt);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: list.f
hw/uart_alu_pkg.sv
hw/baud_tick_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/alu.sv
hw/alu_uart_ctrl.sv
hw/uart_alu_top.sv
tb/uart_alu_sva.sv
tb/tb_uart_alu.sv

// File: Makefile
TOP := tb_uart_alu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
